/* source/rob_pkg.sv */
/*
	reorder buffer shared definitions
	sizes, pointer widths and the vector types that move between
	the per-thread banks, the merge logic and the top level
*/
`default_nettype none

package rob_pkg;

	// buffer geometry, per thread
	localparam int rob_size  = 16;
	localparam int rob_ptr_w = 4;	// log2 of rob_size

	// instruction and branch target program counter
	typedef logic [63:0] pc_t;

	// architectural destination register
	typedef logic [4:0] arn_t;

	// physical destination register, 64 in the file
	typedef logic [5:0] prn_t;

	// slot index inside one bank
	typedef logic [rob_ptr_w-1:0] rob_ptr_t;

	// reorder tag handed to the reservation stations
	// top bit picks the bank (0 thread 1, 1 thread 2), low bits are the slot
	typedef logic [rob_ptr_w:0] rob_tag_t;

	// entries leaving one bank in a cycle, 0 to 2
	typedef logic [1:0] retire_cnt_t;

	// destination shown on an empty commit slot
	localparam arn_t zero_reg = 5'd31;

endpackage

`default_nettype wire

/* source/thread_rob_bank.sv */
/*
	reorder buffer bank for one thread
	circular store of rob_size entries with head, tail and occupancy,
	dispatch writes at the tail, completion writes by tag, in-order
	retire driven by the merge logic, full flush on a mispredict
*/
`timescale 1ns/1ps
`default_nettype none

module thread_rob_bank #(
	parameter logic bank_id = 1'b0	// 0 serves thread 1, 1 serves thread 2
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  is_thread1,
	input  logic                  inst1_load,
	input  logic                  inst2_load,
	input  rob_pkg::pc_t          inst1_pc,
	input  rob_pkg::arn_t         inst1_arn,
	input  rob_pkg::prn_t         inst1_prn,
	input  logic                  inst1_is_branch,
	input  rob_pkg::pc_t          inst2_pc,
	input  rob_pkg::arn_t         inst2_arn,
	input  rob_pkg::prn_t         inst2_prn,
	input  logic                  inst2_is_branch,
	input  logic                  fu1_done,
	input  rob_pkg::rob_tag_t     fu1_tag,
	input  logic                  fu1_mispredict,
	input  rob_pkg::pc_t          fu1_target,
	input  logic                  fu2_done,
	input  rob_pkg::rob_tag_t     fu2_tag,
	input  logic                  fu2_mispredict,
	input  rob_pkg::pc_t          fu2_target,
	input  rob_pkg::retire_cnt_t  retire_count,
	input  logic                  flush,
	output logic                  head0_ready,
	output rob_pkg::pc_t          head0_pc,
	output rob_pkg::pc_t          head0_target,
	output logic                  head0_is_branch,
	output logic                  head0_mispredict,
	output rob_pkg::arn_t         head0_arn,
	output rob_pkg::prn_t         head0_prn,
	output logic                  head1_ready,
	output rob_pkg::pc_t          head1_pc,
	output rob_pkg::pc_t          head1_target,
	output logic                  head1_is_branch,
	output logic                  head1_mispredict,
	output rob_pkg::arn_t         head1_arn,
	output rob_pkg::prn_t         head1_prn,
	output rob_pkg::rob_ptr_t     head,
	output rob_pkg::rob_ptr_t     tail,
	output logic                  full
);
	import rob_pkg::*;

	// per-entry flags
	logic [rob_size-1:0] occupied;
	logic [rob_size-1:0] executed;
	logic [rob_size-1:0] entry_branch;
	logic [rob_size-1:0] entry_mispredict;

	// per-entry payload
	pc_t  entry_pc     [rob_size];
	pc_t  entry_target [rob_size];
	arn_t entry_arn    [rob_size];
	prn_t entry_prn    [rob_size];

	logic [rob_ptr_w:0] count;	// occupancy, 0 to rob_size
	rob_ptr_t head_next;	// second oldest slot
	rob_ptr_t tail_next;	// slot for the second dispatched instruction
	rob_ptr_t head_after;	// head once this cycle's retires are done
	logic bank_sel;
	logic load1;
	logic load2;
	logic [1:0] load_cnt;
	rob_ptr_t fu1_idx;
	rob_ptr_t fu2_idx;
	logic fu1_hit;
	logic fu2_hit;

	assign head_next  = head + rob_ptr_t'(1);
	assign tail_next  = tail + rob_ptr_t'(1);
	assign head_after = head + rob_ptr_t'(retire_count);

	// dispatch is for us when the thread matches, dropped under flush
	assign bank_sel = (is_thread1 != bank_id);
	assign load1    = bank_sel & inst1_load & ~flush;
	assign load2    = load1 & inst2_load;
	assign load_cnt = {1'b0, load1} + {1'b0, load2};

	// completions only touch live entries of this bank
	assign fu1_idx = fu1_tag[rob_ptr_w-1:0];
	assign fu2_idx = fu2_tag[rob_ptr_w-1:0];
	assign fu1_hit = fu1_done && (fu1_tag[rob_ptr_w] == bank_id) && occupied[fu1_idx];
	assign fu2_hit = fu2_done && (fu2_tag[rob_ptr_w] == bank_id) && occupied[fu2_idx];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head     <= '0;
			tail     <= '0;
			count    <= '0;
			occupied <= '0;
			executed <= '0;
		end
		else
		begin
			head <= head_after;
			if (flush)
			begin
				tail     <= head_after;	// empty, tail meets the new head
				count    <= '0;
				occupied <= '0;
				executed <= '0;
			end
			else
			begin
				tail  <= tail + rob_ptr_t'(load_cnt);
				count <= count + {{(rob_ptr_w-1){1'b0}}, load_cnt}
					- {{(rob_ptr_w-1){1'b0}}, retire_count};
				if (retire_count != 2'd0)
					occupied[head] <= 1'b0;
				if (retire_count == 2'd2)
					occupied[head_next] <= 1'b0;
				if (fu1_hit)
					executed[fu1_idx] <= 1'b1;
				if (fu2_hit)
					executed[fu2_idx] <= 1'b1;	// later write, port 2 wins
				if (load1)
				begin
					occupied[tail] <= 1'b1;
					executed[tail] <= 1'b0;
				end
				if (load2)
				begin
					occupied[tail_next] <= 1'b1;
					executed[tail_next] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (load1)
		begin
			entry_pc[tail]     <= inst1_pc;
			entry_arn[tail]    <= inst1_arn;
			entry_prn[tail]    <= inst1_prn;
			entry_branch[tail] <= inst1_is_branch;
		end
		if (load2)
		begin
			entry_pc[tail_next]     <= inst2_pc;
			entry_arn[tail_next]    <= inst2_arn;
			entry_prn[tail_next]    <= inst2_prn;
			entry_branch[tail_next] <= inst2_is_branch;
		end
		if (fu1_hit)
		begin
			entry_target[fu1_idx]     <= fu1_target;
			entry_mispredict[fu1_idx] <= fu1_mispredict;
		end
		if (fu2_hit)
		begin
			entry_target[fu2_idx]     <= fu2_target;
			entry_mispredict[fu2_idx] <= fu2_mispredict;
		end
	end

	// two oldest entries toward the merge logic
	assign head0_ready      = occupied[head] & executed[head];
	assign head0_pc         = entry_pc[head];
	assign head0_target     = entry_target[head];
	assign head0_is_branch  = entry_branch[head];
	assign head0_mispredict = entry_mispredict[head];
	assign head0_arn        = entry_arn[head];
	assign head0_prn        = entry_prn[head];

	assign head1_ready      = occupied[head_next] & executed[head_next];
	assign head1_pc         = entry_pc[head_next];
	assign head1_target     = entry_target[head_next];
	assign head1_is_branch  = entry_branch[head_next];
	assign head1_mispredict = entry_mispredict[head_next];
	assign head1_arn        = entry_arn[head_next];
	assign head1_prn        = entry_prn[head_next];

	// one slot of slack so a dispatched pair always fits
	assign full = (int'(count) >= rob_size - 1);

endmodule

`default_nettype wire

/* source/rob_thread_merge.sv */
/*
	thread merge for the reorder buffer
	forms dispatch tags from the bank tails, picks the two commit slots
	with thread 1 first, and returns retire counts and flush to the banks
*/
`timescale 1ns/1ps
`default_nettype none

module rob_thread_merge (
	input  logic                  is_thread1,
	input  logic                  inst1_load,
	input  logic                  inst2_load,
	input  rob_pkg::rob_ptr_t     t1_tail,
	input  rob_pkg::rob_ptr_t     t2_tail,
	input  logic                  t1_head0_ready,
	input  rob_pkg::pc_t          t1_head0_pc,
	input  rob_pkg::pc_t          t1_head0_target,
	input  logic                  t1_head0_is_branch,
	input  logic                  t1_head0_mispredict,
	input  rob_pkg::arn_t         t1_head0_arn,
	input  rob_pkg::prn_t         t1_head0_prn,
	input  logic                  t1_head1_ready,
	input  rob_pkg::pc_t          t1_head1_pc,
	input  rob_pkg::pc_t          t1_head1_target,
	input  logic                  t1_head1_is_branch,
	input  logic                  t1_head1_mispredict,
	input  rob_pkg::arn_t         t1_head1_arn,
	input  rob_pkg::prn_t         t1_head1_prn,
	input  logic                  t2_head0_ready,
	input  rob_pkg::pc_t          t2_head0_pc,
	input  rob_pkg::pc_t          t2_head0_target,
	input  logic                  t2_head0_is_branch,
	input  logic                  t2_head0_mispredict,
	input  rob_pkg::arn_t         t2_head0_arn,
	input  rob_pkg::prn_t         t2_head0_prn,
	input  logic                  t2_head1_ready,
	input  rob_pkg::pc_t          t2_head1_pc,
	input  rob_pkg::pc_t          t2_head1_target,
	input  logic                  t2_head1_is_branch,
	input  logic                  t2_head1_mispredict,
	input  rob_pkg::arn_t         t2_head1_arn,
	input  rob_pkg::prn_t         t2_head1_prn,
	output rob_pkg::rob_tag_t     inst1_tag,
	output rob_pkg::rob_tag_t     inst2_tag,
	output rob_pkg::retire_cnt_t  t1_retire_count,
	output rob_pkg::retire_cnt_t  t2_retire_count,
	output logic                  t1_flush,
	output logic                  t2_flush,
	output logic                  commit1_valid,
	output rob_pkg::pc_t          commit1_pc,
	output rob_pkg::pc_t          commit1_target,
	output logic                  commit1_is_branch,
	output logic                  commit1_mispredict,
	output rob_pkg::arn_t         commit1_arn,
	output rob_pkg::prn_t         commit1_prn,
	output logic                  commit1_is_thread1,
	output logic                  commit2_valid,
	output rob_pkg::pc_t          commit2_pc,
	output rob_pkg::pc_t          commit2_target,
	output logic                  commit2_is_branch,
	output logic                  commit2_mispredict,
	output rob_pkg::arn_t         commit2_arn,
	output rob_pkg::prn_t         commit2_prn,
	output logic                  commit2_is_thread1
);
	import rob_pkg::*;

	rob_ptr_t disp_tail;
	logic disp_bank;
	logic sel1_t1;	// slot 1 from thread 1 head0
	logic sel1_t2;	// slot 1 from thread 2 head0
	logic sel2_t1_head1;
	logic sel2_t2_head1;
	logic sel2_t2_head0;	// thread 2 fills in behind thread 1

	// tags come straight off the selected tail
	assign disp_bank = ~is_thread1;
	assign disp_tail = is_thread1 ? t1_tail : t2_tail;
	assign inst1_tag = inst1_load ? {disp_bank, disp_tail} : '0;
	assign inst2_tag = (inst1_load && inst2_load) ? {disp_bank, disp_tail + rob_ptr_t'(1)} : '0;

	assign sel1_t1 = t1_head0_ready;
	assign sel1_t2 = ~t1_head0_ready & t2_head0_ready;
	assign commit1_mispredict = (sel1_t1 & t1_head0_is_branch & t1_head0_mispredict)
		| (sel1_t2 & t2_head0_is_branch & t2_head0_mispredict);

	// nothing younger of the same thread passes a mispredicted branch
	assign sel2_t1_head1 = sel1_t1 & t1_head1_ready & ~commit1_mispredict;
	assign sel2_t2_head1 = sel1_t2 & t2_head1_ready & ~commit1_mispredict;
	assign sel2_t2_head0 = sel1_t1 & ~sel2_t1_head1 & t2_head0_ready;

	always_comb
	begin
		commit1_valid      = sel1_t1 | sel1_t2;
		commit1_is_thread1 = sel1_t1;
		commit1_pc         = '0;
		commit1_target     = '0;
		commit1_is_branch  = 1'b0;
		commit1_arn        = zero_reg;
		commit1_prn        = '0;
		if (sel1_t1)
		begin
			commit1_pc        = t1_head0_pc;
			commit1_target    = t1_head0_target;
			commit1_is_branch = t1_head0_is_branch;
			commit1_arn       = t1_head0_arn;
			commit1_prn       = t1_head0_prn;
		end
		else if (sel1_t2)
		begin
			commit1_pc        = t2_head0_pc;
			commit1_target    = t2_head0_target;
			commit1_is_branch = t2_head0_is_branch;
			commit1_arn       = t2_head0_arn;
			commit1_prn       = t2_head0_prn;
		end
	end

	always_comb
	begin
		commit2_valid      = sel2_t1_head1 | sel2_t2_head1 | sel2_t2_head0;
		commit2_is_thread1 = sel2_t1_head1;
		commit2_pc         = '0;
		commit2_target     = '0;
		commit2_is_branch  = 1'b0;
		commit2_mispredict = 1'b0;
		commit2_arn        = zero_reg;
		commit2_prn        = '0;
		if (sel2_t1_head1)
		begin
			commit2_pc         = t1_head1_pc;
			commit2_target     = t1_head1_target;
			commit2_is_branch  = t1_head1_is_branch;
			commit2_mispredict = t1_head1_is_branch & t1_head1_mispredict;
			commit2_arn        = t1_head1_arn;
			commit2_prn        = t1_head1_prn;
		end
		else if (sel2_t2_head1)
		begin
			commit2_pc         = t2_head1_pc;
			commit2_target     = t2_head1_target;
			commit2_is_branch  = t2_head1_is_branch;
			commit2_mispredict = t2_head1_is_branch & t2_head1_mispredict;
			commit2_arn        = t2_head1_arn;
			commit2_prn        = t2_head1_prn;
		end
		else if (sel2_t2_head0)
		begin
			commit2_pc         = t2_head0_pc;
			commit2_target     = t2_head0_target;
			commit2_is_branch  = t2_head0_is_branch;
			commit2_mispredict = t2_head0_is_branch & t2_head0_mispredict;
			commit2_arn        = t2_head0_arn;
			commit2_prn        = t2_head0_prn;
		end
	end

	// retire counts include the mispredicted branch itself
	assign t1_retire_count = {1'b0, sel1_t1} + {1'b0, sel2_t1_head1};
	assign t2_retire_count = {1'b0, sel1_t2} + {1'b0, sel2_t2_head1 | sel2_t2_head0};

	assign t1_flush = (sel1_t1 & commit1_mispredict) | (sel2_t1_head1 & commit2_mispredict);
	assign t2_flush = (sel1_t2 & commit1_mispredict)
		| ((sel2_t2_head1 | sel2_t2_head0) & commit2_mispredict);

endmodule

`default_nettype wire

/* source/smt_rob.sv */
/*
	two-thread reorder buffer
	one bank per thread side by side, joined by the merge block
	that hands out tags and drives the two commit slots
*/
`timescale 1ns/1ps
`default_nettype none

module smt_rob (
	input  logic               clock,
	input  logic               reset,
	input  logic               is_thread1,
	input  logic               inst1_load,
	input  logic               inst2_load,
	input  rob_pkg::pc_t       inst1_pc,
	input  rob_pkg::arn_t      inst1_arn,
	input  rob_pkg::prn_t      inst1_prn,
	input  logic               inst1_is_branch,
	input  rob_pkg::pc_t       inst2_pc,
	input  rob_pkg::arn_t      inst2_arn,
	input  rob_pkg::prn_t      inst2_prn,
	input  logic               inst2_is_branch,
	input  logic               fu1_done,
	input  rob_pkg::rob_tag_t  fu1_tag,
	input  logic               fu1_mispredict,
	input  rob_pkg::pc_t       fu1_target,
	input  logic               fu2_done,
	input  rob_pkg::rob_tag_t  fu2_tag,
	input  logic               fu2_mispredict,
	input  rob_pkg::pc_t       fu2_target,
	output rob_pkg::rob_tag_t  inst1_tag,
	output rob_pkg::rob_tag_t  inst2_tag,
	output logic               commit1_valid,
	output rob_pkg::pc_t       commit1_pc,
	output rob_pkg::pc_t       commit1_target,
	output logic               commit1_is_branch,
	output logic               commit1_mispredict,
	output rob_pkg::arn_t      commit1_arn,
	output rob_pkg::prn_t      commit1_prn,
	output logic               commit1_is_thread1,
	output logic               commit2_valid,
	output rob_pkg::pc_t       commit2_pc,
	output rob_pkg::pc_t       commit2_target,
	output logic               commit2_is_branch,
	output logic               commit2_mispredict,
	output rob_pkg::arn_t      commit2_arn,
	output rob_pkg::prn_t      commit2_prn,
	output logic               commit2_is_thread1,
	output logic               t1_full,
	output logic               t2_full,
	output rob_pkg::rob_ptr_t  t1_head,
	output rob_pkg::rob_ptr_t  t2_head
);
	import rob_pkg::*;

	// oldest two entries of each bank
	logic t1_head0_ready, t1_head1_ready, t2_head0_ready, t2_head1_ready;
	pc_t  t1_head0_pc, t1_head1_pc, t2_head0_pc, t2_head1_pc;
	pc_t  t1_head0_target, t1_head1_target, t2_head0_target, t2_head1_target;
	logic t1_head0_is_branch, t1_head1_is_branch, t2_head0_is_branch, t2_head1_is_branch;
	logic t1_head0_mispredict, t1_head1_mispredict;
	logic t2_head0_mispredict, t2_head1_mispredict;
	arn_t t1_head0_arn, t1_head1_arn, t2_head0_arn, t2_head1_arn;
	prn_t t1_head0_prn, t1_head1_prn, t2_head0_prn, t2_head1_prn;

	rob_ptr_t t1_tail, t2_tail;
	retire_cnt_t t1_retire_count, t2_retire_count;	// from merge, per bank
	logic t1_flush, t2_flush;

	// thread 1 bank, tag bank bit 0
	thread_rob_bank #(.bank_id(1'b0)) t1_bank_inst (
		.*,
		.retire_count     (t1_retire_count),
		.flush            (t1_flush),
		.head0_ready      (t1_head0_ready),
		.head0_pc         (t1_head0_pc),
		.head0_target     (t1_head0_target),
		.head0_is_branch  (t1_head0_is_branch),
		.head0_mispredict (t1_head0_mispredict),
		.head0_arn        (t1_head0_arn),
		.head0_prn        (t1_head0_prn),
		.head1_ready      (t1_head1_ready),
		.head1_pc         (t1_head1_pc),
		.head1_target     (t1_head1_target),
		.head1_is_branch  (t1_head1_is_branch),
		.head1_mispredict (t1_head1_mispredict),
		.head1_arn        (t1_head1_arn),
		.head1_prn        (t1_head1_prn),
		.head             (t1_head),
		.tail             (t1_tail),
		.full             (t1_full)
	);

	thread_rob_bank #(.bank_id(1'b1)) t2_bank_inst (
		.*,
		.retire_count     (t2_retire_count),
		.flush            (t2_flush),
		.head0_ready      (t2_head0_ready),
		.head0_pc         (t2_head0_pc),
		.head0_target     (t2_head0_target),
		.head0_is_branch  (t2_head0_is_branch),
		.head0_mispredict (t2_head0_mispredict),
		.head0_arn        (t2_head0_arn),
		.head0_prn        (t2_head0_prn),
		.head1_ready      (t2_head1_ready),
		.head1_pc         (t2_head1_pc),
		.head1_target     (t2_head1_target),
		.head1_is_branch  (t2_head1_is_branch),
		.head1_mispredict (t2_head1_mispredict),
		.head1_arn        (t2_head1_arn),
		.head1_prn        (t2_head1_prn),
		.head             (t2_head),
		.tail             (t2_tail),
		.full             (t2_full)
	);

	// port names line up with the wires and top ports above
	rob_thread_merge merge_inst (.*);

endmodule

`default_nettype wire

/* verification/clock_gen.sv */
/*
	testbench clock and reset source
	8 ns clock, reset held high for the first 3 cycles
*/
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clock,
	output logic reset
);
	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;	// released off the edge like the other inputs
	end

endmodule

`default_nettype wire

/* verification/smt_rob_tb.sv */
/*
	testbench for the two-thread reorder buffer
	directed tests for dispatch tags, in-order commit, thread merge,
	mispredict flush and the full flag
*/
`timescale 1ns/1ps
`default_nettype none

module smt_rob_tb;
	import rob_pkg::*;

	logic clock;
	logic reset;
	logic is_thread1, inst1_load, inst2_load;
	pc_t inst1_pc, inst2_pc;
	arn_t inst1_arn, inst2_arn;
	prn_t inst1_prn, inst2_prn;
	logic inst1_is_branch, inst2_is_branch;
	logic fu1_done, fu1_mispredict, fu2_done, fu2_mispredict;
	rob_tag_t fu1_tag, fu2_tag;
	pc_t fu1_target, fu2_target;
	rob_tag_t inst1_tag, inst2_tag;
	logic commit1_valid, commit1_is_branch, commit1_mispredict, commit1_is_thread1;
	logic commit2_valid, commit2_is_branch, commit2_mispredict, commit2_is_thread1;
	pc_t commit1_pc, commit1_target, commit2_pc, commit2_target;
	arn_t commit1_arn, commit2_arn;
	prn_t commit1_prn, commit2_prn;
	logic t1_full, t2_full;
	rob_ptr_t t1_head, t2_head;

	int checks = 0;
	int errors = 0;
	int seed = 32'h687f;
	int seq = 0;	// dispatch counter, source of unique pc/arn/prn
	rob_ptr_t t1_tail_m = '0;	// expected tails
	rob_ptr_t t2_tail_m = '0;
	pc_t exp_pc [32];	// dispatched fields, indexed by tag
	arn_t exp_arn [32];
	prn_t exp_prn [32];
	logic exp_branch [32];
	pc_t exp_target [32];	// completion fields, indexed by tag
	logic exp_mis [32];

	clock_gen clock_gen_inst (.clock(clock), .reset(reset));

	smt_rob smt_rob_inst (.*);

	task check_value(input string name, input logic [63:0] actual, input logic [63:0] expected);
		begin
			checks++;
			if (actual !== expected)
			begin
				errors++;
				$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
			end
		end
	endtask

	// next cycle, 1 ns after the edge, strobes back to idle
	task step();
		begin
			@(posedge clock);
			#1;
			inst1_load = 1'b0;
			inst2_load = 1'b0;
			fu1_done = 1'b0;
			fu2_done = 1'b0;
			fu1_mispredict = 1'b0;
			fu2_mispredict = 1'b0;
		end
	endtask

	task dispatch(input logic thread1, input logic two, input logic br1);
		rob_tag_t tag1;
		rob_tag_t tag2;
		begin
			tag1 = thread1 ? {1'b0, t1_tail_m} : {1'b1, t2_tail_m};
			tag2 = {tag1[4], tag1[3:0] + 4'd1};
			step();
			is_thread1 = thread1;
			inst1_load = 1'b1;
			inst2_load = two;
			inst1_pc = 64'h1000 + 64'(seq) * 64'd4;
			inst1_arn = arn_t'(seq % 31);
			inst1_prn = prn_t'(seq % 64);
			inst1_is_branch = br1;
			exp_pc[tag1] = inst1_pc;
			exp_arn[tag1] = inst1_arn;
			exp_prn[tag1] = inst1_prn;
			exp_branch[tag1] = br1;
			seq++;
			inst2_pc = 64'h1000 + 64'(seq) * 64'd4;
			inst2_arn = arn_t'(seq % 31);
			inst2_prn = prn_t'(seq % 64);
			inst2_is_branch = 1'b0;
			if (two)
			begin
				exp_pc[tag2] = inst2_pc;
				exp_arn[tag2] = inst2_arn;
				exp_prn[tag2] = inst2_prn;
				exp_branch[tag2] = 1'b0;
				seq++;
			end
			#2;
			check_value("inst1_tag", 64'(inst1_tag), 64'(tag1));
			check_value("inst2_tag", 64'(inst2_tag), two ? 64'(tag2) : 64'd0);
			if (thread1)
				t1_tail_m = t1_tail_m + (two ? 4'd2 : 4'd1);
			else
				t2_tail_m = t2_tail_m + (two ? 4'd2 : 4'd1);
		end
	endtask

	task complete(input logic v1, input rob_tag_t tag1, input logic mis1, input pc_t target1,
		input logic v2, input rob_tag_t tag2);
		begin
			step();
			fu1_done = v1;
			fu1_tag = tag1;
			fu1_mispredict = mis1;
			fu1_target = target1;
			fu2_done = v2;
			fu2_tag = tag2;
			fu2_target = 64'h0;
			if (v1)
			begin
				exp_target[tag1] = target1;
				exp_mis[tag1] = mis1;
			end
			if (v2)
			begin
				exp_target[tag2] = 64'h0;	// port 2 wins on a shared tag
				exp_mis[tag2] = 1'b0;
			end
		end
	endtask

	// compares one commit slot of the current cycle with a dispatched tag
	task expect_slot(input int slot, input logic valid, input rob_tag_t tag);
		logic v;
		logic t1;
		logic br;
		logic mis;
		pc_t pc;
		pc_t tgt;
		arn_t arn;
		prn_t prn;
		string p;
		begin
			p = (slot == 1) ? "commit1" : "commit2";
			v = (slot == 1) ? commit1_valid : commit2_valid;
			t1 = (slot == 1) ? commit1_is_thread1 : commit2_is_thread1;
			br = (slot == 1) ? commit1_is_branch : commit2_is_branch;
			mis = (slot == 1) ? commit1_mispredict : commit2_mispredict;
			pc = (slot == 1) ? commit1_pc : commit2_pc;
			tgt = (slot == 1) ? commit1_target : commit2_target;
			arn = (slot == 1) ? commit1_arn : commit2_arn;
			prn = (slot == 1) ? commit1_prn : commit2_prn;
			check_value({p, "_valid"}, 64'(v), 64'(valid));
			if (valid)
			begin
				check_value({p, "_pc"}, pc, exp_pc[tag]);
				check_value({p, "_target"}, tgt, exp_target[tag]);
				check_value({p, "_is_branch"}, 64'(br), 64'(exp_branch[tag]));
				check_value({p, "_mispredict"}, 64'(mis), 64'(exp_branch[tag] & exp_mis[tag]));
				check_value({p, "_arn"}, 64'(arn), 64'(exp_arn[tag]));
				check_value({p, "_prn"}, 64'(prn), 64'(exp_prn[tag]));
				check_value({p, "_is_thread1"}, 64'(t1), 64'(!tag[4]));
			end
			else
			begin
				check_value({p, "_pc"}, pc, 64'h0);
				check_value({p, "_target"}, tgt, 64'h0);
				check_value({p, "_is_branch"}, 64'(br), 64'd0);
				check_value({p, "_mispredict"}, 64'(mis), 64'd0);
				check_value({p, "_arn"}, 64'(arn), 64'(zero_reg));
				check_value({p, "_prn"}, 64'(prn), 64'd0);
				check_value({p, "_is_thread1"}, 64'(t1), 64'd0);
			end
		end
	endtask

	task wait_commit();
		int n;
		begin
			n = 0;
			step();
			#2;
			while (!commit1_valid && n < 20)
			begin
				step();
				#2;
				n++;
			end
			if (!commit1_valid)
			begin
				errors++;
				$display("timeout at %0t: no commit seen within %0d cycles", $time, n);
			end
		end
	endtask

	task tags_on_dispatch();
		begin
			dispatch(1'b1, 1'b1, 1'b0);	// tags 0, 1
			dispatch(1'b1, 1'b1, 1'b0);	// tags 2, 3
			dispatch(1'b0, 1'b0, 1'b0);	// tag 16
			dispatch(1'b0, 1'b1, 1'b0);	// tags 17, 18
			$display("dispatch tags done, errors so far %0d", errors);
		end
	endtask

	task commit_in_order();
		int order [4];
		logic done_f [6];
		int i, j, tmp, p;
		int seen;
		logic exp1, exp2;
		begin
			for (i = 0; i < 4; i++)
				order[i] = i;
			for (i = 0; i < 6; i++)
				done_f[i] = 1'b0;
			for (i = 3; i > 0; i--)
			begin
				j = int'({$random(seed)} % (i + 1));
				tmp = order[i];
				order[i] = order[j];
				order[j] = tmp;
			end
			p = 0;
			seen = 0;
			for (i = 0; i < 7; i++)
			begin
				if (i < 4)
					complete(1'b1, rob_tag_t'(order[i]), 1'b0, 64'h0, 1'b0, 5'd0);
				else
					step();
				#2;
				exp1 = (p < 4) && done_f[p];
				exp2 = exp1 && (p < 3) && done_f[p + 1];
				expect_slot(1, exp1, rob_tag_t'(p));
				expect_slot(2, exp2, rob_tag_t'(p + 1));
				p = p + int'(exp1) + int'(exp2);
				seen = seen + int'(commit1_valid) + int'(commit2_valid);	// commits on the outputs
				if (i < 4)
					done_f[order[i]] = 1'b1;
			end
			check_value("thread 1 commits", 64'(seen), 64'd4);
			$display("in-order commit done, errors so far %0d", errors);
		end
	endtask

	task merge_threads();
		begin
			dispatch(1'b1, 1'b1, 1'b0);	// tags 4, 5
			complete(1'b1, 5'd17, 1'b0, 64'h0, 1'b0, 5'd0);
			complete(1'b1, 5'd4, 1'b0, 64'h0, 1'b1, 5'd16);
			#2;
			expect_slot(1, 1'b0, 5'd0);	// 17 is done but waits behind 16
			expect_slot(2, 1'b0, 5'd0);
			wait_commit();
			expect_slot(1, 1'b1, 5'd4);
			expect_slot(2, 1'b1, 5'd16);
			step();
			#2;
			expect_slot(1, 1'b1, 5'd17);
			expect_slot(2, 1'b0, 5'd0);
			complete(1'b1, 5'd5, 1'b0, 64'h0, 1'b1, 5'd18);
			wait_commit();
			expect_slot(1, 1'b1, 5'd5);
			expect_slot(2, 1'b1, 5'd18);
			$display("thread merge done, errors so far %0d", errors);
		end
	endtask

	task flush_on_mispredict();
		pc_t target;
		int i;
		begin
			target = 64'h0000_0000_0000_8040;
			dispatch(1'b1, 1'b1, 1'b1);	// branch 6, younger 7
			dispatch(1'b1, 1'b1, 1'b0);	// younger 8, 9
			dispatch(1'b0, 1'b0, 1'b0);	// thread 2 tag 19
			complete(1'b1, 5'd7, 1'b0, 64'h0, 1'b1, 5'd8);
			complete(1'b1, 5'd9, 1'b0, 64'h0, 1'b0, 5'd0);
			#2;
			expect_slot(1, 1'b0, 5'd0);
			complete(1'b1, 5'd6, 1'b1, target, 1'b1, 5'd19);
			wait_commit();
			expect_slot(1, 1'b1, 5'd6);	// branch, mispredict and target
			expect_slot(2, 1'b1, 5'd19);
			t1_tail_m = 4'd7;	// emptied, tail meets head after the branch
			for (i = 0; i < 4; i++)
			begin
				step();
				#2;
				check_value("commit1_valid", 64'(commit1_valid), 64'd0);
				check_value("commit2_valid", 64'(commit2_valid), 64'd0);
			end
			check_value("t1_head", 64'(t1_head), 64'd7);
			check_value("t2_head", 64'(t2_head), 64'd4);
			dispatch(1'b1, 1'b0, 1'b0);	// tag lands on the new head
			dispatch(1'b0, 1'b0, 1'b0);	// thread 2 tag 20
			complete(1'b1, 5'd7, 1'b0, 64'h0, 1'b1, 5'd20);
			wait_commit();
			expect_slot(1, 1'b1, 5'd7);
			expect_slot(2, 1'b1, 5'd20);
			$display("mispredict flush done, errors so far %0d", errors);
		end
	endtask

	task fill_to_full();
		rob_tag_t first;
		int i;
		begin
			first = {1'b0, t1_tail_m};
			for (i = 0; i < 15; i++)
			begin
				dispatch(1'b1, 1'b0, 1'b0);
				check_value("t1_full", 64'(t1_full), 64'd0);
			end
			step();
			#2;
			check_value("t1_full", 64'(t1_full), 64'd1);
			check_value("t2_full", 64'(t2_full), 64'd0);
			complete(1'b1, first, 1'b0, 64'h0, 1'b1, {1'b0, first[3:0] + 4'd1});
			wait_commit();
			expect_slot(1, 1'b1, first);
			expect_slot(2, 1'b1, {1'b0, first[3:0] + 4'd1});
			step();
			#2;
			check_value("t1_full", 64'(t1_full), 64'd0);
			$display("full flag done, errors so far %0d", errors);
		end
	endtask

	initial
	begin
		int n;
		is_thread1 = 1'b1;
		inst1_load = 1'b0;
		inst2_load = 1'b0;
		inst1_pc = '0;
		inst2_pc = '0;
		inst1_arn = '0;
		inst2_arn = '0;
		inst1_prn = '0;
		inst2_prn = '0;
		inst1_is_branch = 1'b0;
		inst2_is_branch = 1'b0;
		fu1_done = 1'b0;
		fu1_tag = '0;
		fu1_mispredict = 1'b0;
		fu1_target = '0;
		fu2_done = 1'b0;
		fu2_tag = '0;
		fu2_mispredict = 1'b0;
		fu2_target = '0;
		n = 0;
		#1;
		while (reset !== 1'b0 && n < 20)
		begin
			@(posedge clock);
			#2;
			n++;
		end
		if (reset !== 1'b0)
		begin
			errors++;
			$display("reset never released");
		end
		check_value("commit1_valid", 64'(commit1_valid), 64'd0);
		check_value("commit2_valid", 64'(commit2_valid), 64'd0);
		check_value("t1_full", 64'(t1_full), 64'd0);
		check_value("t2_full", 64'(t2_full), 64'd0);
		check_value("t1_head", 64'(t1_head), 64'd0);
		check_value("t2_head", 64'(t2_head), 64'd0);
		tags_on_dispatch();
		commit_in_order();
		merge_threads();
		flush_on_mispredict();
		fill_to_full();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
source/rob_pkg.sv
source/thread_rob_bank.sv
source/rob_thread_merge.sv
source/smt_rob.sv
verification/clock_gen.sv
verification/smt_rob_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module smt_rob_tb -o sim_smt_rob &&
./obj_dir/sim_smt_rob | tee /dev/stderr | grep -q "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
